// File: apb_i2c.f
+incdir+common
common/i2c_pkg.sv
design/byte_fifo.sv
design/apb_regs.sv
i2c/i2c_bit_timer.sv
i2c/i2c_master.sv
design/apb_i2c_top.sv
dv/i2c_target_model.sv
dv/apb_i2c_tb.sv

// File: dv/apb_i2c_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module apb_i2c_tb;

    localparam int         clk_period    = 100;
    localparam int         n_rows        = 7;
    localparam longint     margin_ns     = 300000;
    localparam logic [7:0] test_prescale = 8'd2;

    typedef struct packed {
        logic [6:0] addr;
        logic       read;
        logic [3:0] count;
        logic       nack;
    } row_t;

    logic                    pclk;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`I2C_PADDR_W-1:0] paddr;
    logic [`I2C_DATA_W-1:0]  pwdata;
    logic [`I2C_DATA_W-1:0]  prdata;
    logic                    scl_out;
    logic                    sda_out;
    logic                    target_sda;
    logic                    sda_line;
    row_t                    rows [n_rows];
    logic [7:0]              row_data [n_rows][8];
    longint                  watchdog_ns;

    // open-drain sda, either side can pull it low
    assign sda_line = sda_out & target_sda;

    apb_i2c_top apb_i2c_top_i (
        .pclk    (pclk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .sda_in  (sda_line),
        .prdata  (prdata),
        .scl_out (scl_out),
        .sda_out (sda_out)
    );

    i2c_target_model target_i (
        .scl       (scl_out),
        .sda       (sda_line),
        .sda_drive (target_sda)
    );

    initial begin
        pclk = 1'b0;
        forever begin
            #(clk_period / 2) pclk = ~pclk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [`I2C_PADDR_W-1:0] addr, input logic [7:0] data);
        @(posedge pclk);
        #10;
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge pclk);
        #10;
        penable = 1'b1;
        @(posedge pclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`I2C_PADDR_W-1:0] addr, output logic [7:0] data);
        @(posedge pclk);
        #10;
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge pclk);
        #10;
        penable = 1'b1;
        @(negedge pclk);
        data = prdata;
        @(posedge pclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // status byte from its flags, bits 1:0 always zero
    function automatic logic [7:0] expected_status(input logic tx_full, input logic rx_empty,
                                                   input logic tx_empty);
        return {tx_full, rx_empty, 1'b0, 1'b0, tx_empty, 1'b0, 2'b00};
    endfunction

    task automatic wait_idle(output i2c_pkg::i2c_status_t status);
        logic [7:0] rdata;
        do begin
            apb_read(i2c_pkg::reg_status, rdata);
            status = rdata;
        end while (status.busy);
    endtask

    task automatic set_row(input int r, input logic [6:0] addr, input logic read,
                           input logic [3:0] count, input logic nack);
        rows[r].addr  = addr;
        rows[r].read  = read;
        rows[r].count = count;
        rows[r].nack  = nack;
        for (int i = 0; i < 8; i++) begin
            row_data[r][i] = $urandom;
        end
    endtask

    task automatic run_row(input int r);
        logic [7:0]           rdata;
        i2c_pkg::xfer_cmd_t   cmd;
        i2c_pkg::i2c_status_t status;
        int                   n_expected;
        apb_write(i2c_pkg::reg_address, {1'b0, rows[r].addr});
        if (!rows[r].read) begin
            for (int i = 0; i < rows[r].count; i++) begin
                apb_write(i2c_pkg::reg_transmit, row_data[r][i]);
            end
        end
        target_i.clear_capture();
        cmd       = '0;
        cmd.go    = 1'b1;
        cmd.read  = rows[r].read;
        cmd.count = rows[r].count;
        apb_write(i2c_pkg::reg_command, cmd);
        wait_idle(status);
        check_value("status.nack", rows[r].nack, status.nack);
        if (rows[r].read) begin
            for (int i = 0; i < rows[r].count; i++) begin
                apb_read(i2c_pkg::reg_receive, rdata);
                check_value("receive", 8'hc0 + i, rdata);
            end
            apb_read(i2c_pkg::reg_status, rdata);
            status = rdata;
            check_value("status.rx_empty", 1'b1, status.rx_empty);
        end else begin
            n_expected = rows[r].nack ? 0 : rows[r].count;
            check_value("capture_count", n_expected, target_i.capture_count);
            for (int i = 0; i < n_expected; i++) begin
                check_value("capture", row_data[r][i], target_i.capture[i]);
            end
        end
        // an aborted write leaves its bytes in the tx fifo
        if (rows[r].nack) begin
            cmd            = '0;
            cmd.fifo_clear = 1'b1;
            apb_write(i2c_pkg::reg_command, cmd);
        end
    endtask

    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog expired, a transfer hung and never finished");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin : stimulus
        logic [7:0]         rdata;
        logic [31:0]        seed;
        longint             bit_ns;
        longint             total_bits;
        i2c_pkg::xfer_cmd_t cmd;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        watchdog_ns = 0;
        seed        = $urandom(32'h856c);

        set_row(0, 7'h2a, 1'b0, 4'd3, 1'b0);
        set_row(1, 7'h2a, 1'b1, 4'd4, 1'b0);
        set_row(2, 7'h15, 1'b0, 4'd2, 1'b1);
        set_row(3, 7'h2a, 1'b0, 4'd8, 1'b0);
        set_row(4, 7'h2a, 1'b1, 4'd1, 1'b0);
        set_row(5, 7'h2a, 1'b0, 4'd0, 1'b0);
        set_row(6, 7'h2a, 1'b1, 4'd8, 1'b0);

        // start and stop add one bit period each
        bit_ns     = 4 * (test_prescale + 1) * clk_period;
        total_bits = 0;
        for (int r = 0; r < n_rows; r++) begin
            total_bits += 9 * (rows[r].count + 1) + 2;
        end
        watchdog_ns = 2 * total_bits * bit_ns + margin_ns;

        repeat (16) @(posedge pclk);
        #10;
        reset = 1'b0;

        // both bus lines released out of reset
        check_value("scl_out", 1'b1, scl_out);
        check_value("sda_out", 1'b1, sda_out);

        apb_read(i2c_pkg::reg_status, rdata);
        check_value("status", expected_status(1'b0, 1'b1, 1'b1), rdata);
        apb_read(i2c_pkg::reg_prescale, rdata);
        check_value("prescale", `I2C_PRESCALE_RST, rdata);
        apb_write(i2c_pkg::reg_prescale, test_prescale);
        apb_read(i2c_pkg::reg_prescale, rdata);
        check_value("prescale", test_prescale, rdata);
        apb_write(i2c_pkg::reg_address, 8'h55);
        apb_read(i2c_pkg::reg_address, rdata);
        check_value("address", 8'h55, rdata);

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        // bus idle again after the last stop
        check_value("scl_out", 1'b1, scl_out);
        check_value("sda_out", 1'b1, sda_out);

        // ninth byte must not get in
        for (int i = 0; i < 9; i++) begin
            apb_write(i2c_pkg::reg_transmit, $urandom);
            if (i >= 7) begin
                apb_read(i2c_pkg::reg_status, rdata);
                check_value("status", expected_status(1'b1, 1'b1, 1'b0), rdata);
            end
        end
        cmd            = '0;
        cmd.fifo_clear = 1'b1;
        apb_write(i2c_pkg::reg_command, cmd);
        apb_read(i2c_pkg::reg_status, rdata);
        check_value("status", expected_status(1'b0, 1'b1, 1'b1), rdata);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/i2c_target_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] own_addr = 7'h2a
) (
    input  wire logic scl,
    input  wire logic sda,
    output logic      sda_drive
);

    logic [7:0] capture [16];
    int         capture_count;

    task automatic clear_capture();
        capture_count = 0;
    endtask

    // sda falling while scl is high
    task automatic wait_start();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge sda);
            seen = (scl === 1'b1);
        end
    endtask

    // eight bits msb first, gives up on a stop
    task automatic receive_byte(output logic [7:0] value, output logic stopped);
        stopped = 1'b0;
        value   = '0;
        for (int i = 0; i < 8; i++) begin
            if (!stopped) begin
                @(posedge scl);
                value = {value[6:0], sda};
                @(negedge scl or posedge sda);
                stopped = (scl === 1'b1);
            end
        end
    endtask

    task automatic send_ack();
        sda_drive = 1'b0;
        @(posedge scl);
        @(negedge scl);
        sda_drive = 1'b1;
    endtask

    // master_ack low means the master wants another byte
    task automatic send_byte(input logic [7:0] value, output logic master_ack);
        for (int i = 7; i >= 0; i--) begin
            sda_drive = value[i];
            @(posedge scl);
            @(negedge scl);
        end
        sda_drive = 1'b1;
        @(posedge scl);
        master_ack = sda;
        @(negedge scl);
    endtask

    initial begin : serve
        logic [7:0] addr_byte;
        logic [7:0] value;
        logic [7:0] index;
        logic       stopped;
        logic       master_ack;
        sda_drive     = 1'b1;
        capture_count = 0;
        forever begin
            wait_start();
            receive_byte(addr_byte, stopped);
            // other addresses are left unanswered
            if (!stopped && (addr_byte[7:1] == own_addr)) begin
                send_ack();
                if (addr_byte[0]) begin
                    index      = 8'd0;
                    master_ack = 1'b0;
                    while (master_ack == 1'b0) begin
                        send_byte(8'hc0 + index, master_ack);
                        index = index + 8'd1;
                    end
                end else begin
                    while (!stopped) begin
                        receive_byte(value, stopped);
                        if (!stopped) begin
                            if (capture_count < 16) begin
                                capture[capture_count] = value;
                            end
                            capture_count++;
                            send_ack();
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/apb_i2c_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module apb_i2c_top (
    input  wire logic                    pclk,
    input  wire logic                    reset,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire logic [`I2C_PADDR_W-1:0] paddr,
    input  wire logic [`I2C_DATA_W-1:0]  pwdata,
    input  wire logic                    sda_in,
    output logic [`I2C_DATA_W-1:0]       prdata,
    output logic                         scl_out,
    output logic                         sda_out
);

    logic [`I2C_DATA_W-1:0] prescale;
    logic [6:0]             target_addr;
    i2c_pkg::xfer_cmd_t     cmd;
    i2c_pkg::fifo_flags_t   tx_flags;
    i2c_pkg::fifo_flags_t   rx_flags;
    logic                   tx_push;
    logic [`I2C_DATA_W-1:0] tx_data;
    logic                   tx_pop;
    logic [`I2C_DATA_W-1:0] tx_head;
    logic                   rx_push;
    logic [`I2C_DATA_W-1:0] rx_data;
    logic                   rx_pop;
    logic [`I2C_DATA_W-1:0] rx_head;
    logic                   fifo_clear;
    logic                   busy;
    logic                   nack;

    apb_regs apb_regs_i (
        .pclk        (pclk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .tx_flags    (tx_flags),
        .rx_flags    (rx_flags),
        .rx_head     (rx_head),
        .busy        (busy),
        .nack        (nack),
        .prdata      (prdata),
        .prescale    (prescale),
        .target_addr (target_addr),
        .cmd         (cmd),
        .tx_push     (tx_push),
        .tx_data     (tx_data),
        .rx_pop      (rx_pop),
        .fifo_clear  (fifo_clear)
    );

    // processor to bus
    byte_fifo tx_fifo (
        .pclk      (pclk),
        .reset     (reset),
        .clear     (fifo_clear),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .flags     (tx_flags)
    );

    // bus to processor
    byte_fifo rx_fifo (
        .pclk      (pclk),
        .reset     (reset),
        .clear     (fifo_clear),
        .push      (rx_push),
        .push_data (rx_data),
        .pop       (rx_pop),
        .head      (rx_head),
        .flags     (rx_flags)
    );

    i2c_master i2c_master_i (
        .pclk        (pclk),
        .reset       (reset),
        .cmd         (cmd),
        .prescale    (prescale),
        .target_addr (target_addr),
        .tx_head     (tx_head),
        .tx_flags    (tx_flags),
        .rx_flags    (rx_flags),
        .sda_in      (sda_in),
        .tx_pop      (tx_pop),
        .rx_push     (rx_push),
        .rx_data     (rx_data),
        .busy        (busy),
        .nack        (nack),
        .scl_out     (scl_out),
        .sda_out     (sda_out)
    );

endmodule

`default_nettype wire

// File: i2c/i2c_master.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module i2c_master (
    input  wire logic                   pclk,
    input  wire logic                   reset,
    input  wire i2c_pkg::xfer_cmd_t     cmd,
    input  wire logic [`I2C_DATA_W-1:0] prescale,
    input  wire logic [6:0]             target_addr,
    input  wire logic [`I2C_DATA_W-1:0] tx_head,
    input  wire i2c_pkg::fifo_flags_t   tx_flags,
    input  wire i2c_pkg::fifo_flags_t   rx_flags,
    input  wire logic                   sda_in,
    output logic                        tx_pop,
    output logic                        rx_push,
    output logic [`I2C_DATA_W-1:0]      rx_data,
    output logic                        busy,
    output logic                        nack,
    output logic                        scl_out,
    output logic                        sda_out
);

    i2c_pkg::i2c_state_e    state;
    logic [1:0]             phase;
    logic [2:0]             bit_cnt;
    logic [3:0]             byte_cnt;
    logic [`I2C_DATA_W-1:0] shift;
    logic                   read_q;
    logic                   sample_q;
    logic                   scl_q;
    logic                   sda_q;
    logic                   sda_bit;
    logic                   tick;
    logic                   bit_end;
    logic                   in_ack;
    logic                   ack_bad;
    logic                   next_ok;
    logic                   load_tx;

    assign busy = (state != i2c_pkg::st_idle);

    i2c_bit_timer bit_timer_i (
        .pclk     (pclk),
        .reset    (reset),
        .run      (busy),
        .prescale (prescale),
        .tick     (tick)
    );

    // phase 0 drives sda with scl low, 1 raises scl,
    // 2 samples with scl high, 3 drops scl again
    assign bit_end = tick && (phase == 2'd3);
    assign in_ack  = (state == i2c_pkg::st_addr_ack) || (state == i2c_pkg::st_tx_ack)
                  || (state == i2c_pkg::st_rx_ack);
    assign ack_bad = sample_q && (state != i2c_pkg::st_rx_ack);
    assign next_ok = bit_end && in_ack && !ack_bad && (byte_cnt != '0);
    assign load_tx = next_ok && !read_q && !tx_flags.empty;

    assign tx_pop  = load_tx;
    assign nack    = bit_end && in_ack && ack_bad;
    assign rx_push = bit_end && (state == i2c_pkg::st_rx_byte) && (bit_cnt == '0)
                  && !rx_flags.full;
    assign rx_data = shift;

    // value put on sda in phase 0
    always_comb begin
        case (state)
            i2c_pkg::st_addr,
            i2c_pkg::st_tx_byte: sda_bit = shift[7];
            // ack all but the last byte read
            i2c_pkg::st_rx_ack:  sda_bit = (byte_cnt == '0);
            i2c_pkg::st_stop:    sda_bit = 1'b0;
            default:             sda_bit = 1'b1;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (tick) begin
            if ((state == i2c_pkg::st_start) && (phase == 2'd3)) begin
                shift <= {target_addr, read_q};
            end else if (load_tx) begin
                shift <= tx_head;
            end else if ((state == i2c_pkg::st_rx_byte) && (phase == 2'd2)) begin
                shift <= {shift[`I2C_DATA_W-2:0], sda_in};
            end else if (((state == i2c_pkg::st_addr) || (state == i2c_pkg::st_tx_byte))
                         && (phase == 2'd3)) begin
                shift <= shift << 1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            state    <= i2c_pkg::st_idle;
            phase    <= 2'd0;
            bit_cnt  <= 3'd7;
            byte_cnt <= '0;
            read_q   <= 1'b0;
            sample_q <= 1'b0;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
        end else if (state == i2c_pkg::st_idle) begin
            if (cmd.go) begin
                state    <= i2c_pkg::st_start;
                phase    <= 2'd0;
                byte_cnt <= cmd.count;
                read_q   <= cmd.read;
            end
        end else if (tick) begin
            phase <= phase + 2'd1;
            case (phase)
                2'd0: sda_q <= sda_bit;
                2'd1: scl_q <= 1'b1;
                2'd2: begin
                    if (state == i2c_pkg::st_start) begin
                        sda_q <= 1'b0;
                    end
                    if (state == i2c_pkg::st_stop) begin
                        sda_q <= 1'b1;
                    end
                    if ((state == i2c_pkg::st_addr_ack) || (state == i2c_pkg::st_tx_ack)) begin
                        sample_q <= sda_in;
                    end
                end
                default: begin
                    if (state != i2c_pkg::st_stop) begin
                        scl_q <= 1'b0;
                    end
                    // bit_cnt wraps back to 7 at the end of each byte
                    case (state)
                        i2c_pkg::st_start: begin
                            state   <= i2c_pkg::st_addr;
                            bit_cnt <= 3'd7;
                        end
                        i2c_pkg::st_addr: begin
                            bit_cnt <= bit_cnt - 3'd1;
                            if (bit_cnt == '0) begin
                                state <= i2c_pkg::st_addr_ack;
                            end
                        end
                        i2c_pkg::st_tx_byte: begin
                            bit_cnt <= bit_cnt - 3'd1;
                            if (bit_cnt == '0) begin
                                state <= i2c_pkg::st_tx_ack;
                            end
                        end
                        i2c_pkg::st_rx_byte: begin
                            bit_cnt <= bit_cnt - 3'd1;
                            if (bit_cnt == '0) begin
                                state <= i2c_pkg::st_rx_ack;
                            end
                        end
                        i2c_pkg::st_addr_ack,
                        i2c_pkg::st_tx_ack,
                        i2c_pkg::st_rx_ack: begin
                            // nack, last byte done or tx fifo dry all end in stop
                            if (next_ok && read_q) begin
                                state    <= i2c_pkg::st_rx_byte;
                                byte_cnt <= byte_cnt - 4'd1;
                            end else if (load_tx) begin
                                state    <= i2c_pkg::st_tx_byte;
                                byte_cnt <= byte_cnt - 4'd1;
                            end else begin
                                state <= i2c_pkg::st_stop;
                            end
                        end
                        default: state <= i2c_pkg::st_idle;
                    endcase
                end
            endcase
        end
    end

    assign scl_out = scl_q;
    assign sda_out = sda_q;

endmodule

`default_nettype wire

// File: i2c/i2c_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module i2c_bit_timer (
    input  wire logic                   pclk,
    input  wire logic                   reset,
    input  wire logic                   run,
    input  wire logic [`I2C_DATA_W-1:0] prescale,
    output logic                        tick
);

    logic [`I2C_DATA_W-1:0] count;

    // parked at prescale while idle, so the first tick
    // lands prescale + 1 cycles after run rises
    always_ff @(posedge pclk) begin
        if (reset) begin
            count <= '0;
        end else if (!run || (count == '0)) begin
            count <= prescale;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign tick = run && (count == '0);

endmodule

`default_nettype wire

// File: design/apb_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module apb_regs (
    input  wire logic                    pclk,
    input  wire logic                    reset,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire logic [`I2C_PADDR_W-1:0] paddr,
    input  wire logic [`I2C_DATA_W-1:0]  pwdata,
    input  wire i2c_pkg::fifo_flags_t    tx_flags,
    input  wire i2c_pkg::fifo_flags_t    rx_flags,
    input  wire logic [`I2C_DATA_W-1:0]  rx_head,
    input  wire logic                    busy,
    input  wire logic                    nack,
    output logic [`I2C_DATA_W-1:0]       prdata,
    output logic [`I2C_DATA_W-1:0]       prescale,
    output logic [6:0]                   target_addr,
    output i2c_pkg::xfer_cmd_t           cmd,
    output logic                         tx_push,
    output logic [`I2C_DATA_W-1:0]       tx_data,
    output logic                         rx_pop,
    output logic                         fifo_clear
);

    logic                   wr_en;
    logic                   rd_en;
    logic [`I2C_DATA_W-1:0] prescale_q;
    logic [6:0]             addr_q;
    i2c_pkg::xfer_cmd_t     cmd_q;
    i2c_pkg::xfer_cmd_t     wr_cmd;
    logic                   go_q;
    logic                   clear_q;
    logic                   nack_q;
    i2c_pkg::i2c_status_t   status;

    // access phase only
    assign wr_en  = psel && penable && pwrite;
    assign rd_en  = psel && penable && !pwrite;
    assign wr_cmd = i2c_pkg::xfer_cmd_t'(pwdata);

    always_ff @(posedge pclk) begin
        if (reset) begin
            prescale_q <= `I2C_PRESCALE_RST;
            addr_q     <= '0;
            cmd_q      <= '0;
            go_q       <= 1'b0;
            clear_q    <= 1'b0;
            nack_q     <= 1'b0;
        end else begin
            go_q    <= 1'b0;
            clear_q <= 1'b0;
            if (nack) begin
                nack_q <= 1'b1;
            end
            if (wr_en) begin
                case (paddr)
                    i2c_pkg::reg_prescale: prescale_q <= pwdata;
                    i2c_pkg::reg_address:  addr_q <= pwdata[6:0];
                    i2c_pkg::reg_command: begin
                        // go and clear are strobes, they read back as 0
                        cmd_q            <= wr_cmd;
                        cmd_q.go         <= 1'b0;
                        cmd_q.fifo_clear <= 1'b0;
                        go_q             <= wr_cmd.go;
                        clear_q          <= wr_cmd.fifo_clear;
                        if (wr_cmd.go) begin
                            nack_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        cmd            = cmd_q;
        cmd.go         = go_q;
        cmd.fifo_clear = clear_q;
    end

    always_comb begin
        status          = '0;
        status.tx_full  = tx_flags.full;
        status.rx_empty = rx_flags.empty;
        status.busy     = busy;
        status.nack     = nack_q;
        status.tx_empty = tx_flags.empty;
        status.rx_full  = rx_flags.full;
    end

    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                i2c_pkg::reg_prescale: prdata = prescale_q;
                i2c_pkg::reg_command:  prdata = cmd_q;
                i2c_pkg::reg_status:   prdata = status;
                i2c_pkg::reg_receive:  prdata = rx_flags.empty ? '0 : rx_head;
                i2c_pkg::reg_address:  prdata = {1'b0, addr_q};
                default:               prdata = '0;
            endcase
        end
    end

    // fifo strobes, guarded by the flags
    assign tx_push     = wr_en && (paddr == i2c_pkg::reg_transmit) && !tx_flags.full;
    assign tx_data     = pwdata;
    assign rx_pop      = rd_en && (paddr == i2c_pkg::reg_receive) && !rx_flags.empty;
    assign fifo_clear  = clear_q;
    assign prescale    = prescale_q;
    assign target_addr = addr_q;

endmodule

`default_nettype wire

// File: design/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "i2c_config.svh"

module byte_fifo #(
    parameter int addr_w = `I2C_FIFO_AW
) (
    input  wire logic                   pclk,
    input  wire logic                   reset,
    input  wire logic                   clear,
    input  wire logic                   push,
    input  wire logic [`I2C_DATA_W-1:0] push_data,
    input  wire logic                   pop,
    output logic [`I2C_DATA_W-1:0]      head,
    output i2c_pkg::fifo_flags_t        flags
);

    localparam int depth = 1 << addr_w;

    logic [`I2C_DATA_W-1:0] mem [depth];

    // extra msb tells a full buffer from an empty one
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;

    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr[addr_w-1:0]] <= push_data;
        end
    end

    always_ff @(posedge pclk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (reset || clear) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign head = mem[rd_ptr[addr_w-1:0]];

    always_comb begin
        flags.empty = (wr_ptr == rd_ptr);
        flags.full  = (wr_ptr[addr_w] != rd_ptr[addr_w])
                   && (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    end

endmodule

`default_nettype wire

// File: common/i2c_pkg.sv
`default_nettype none
`include "i2c_config.svh"

package i2c_pkg;

    // register offsets on the APB bus
    typedef enum logic [`I2C_PADDR_W-1:0] {
        reg_prescale = 'd0,
        reg_command  = 'd1,
        reg_status   = 'd2,
        reg_transmit = 'd3,
        reg_receive  = 'd4,
        reg_address  = 'd5
    } reg_addr_e;

    // command register layout
    typedef struct packed {
        logic       go;
        logic       fifo_clear;
        logic       read;
        logic [3:0] count;
        logic       spare;
    } xfer_cmd_t;

    typedef struct packed {
        logic       tx_full;
        logic       rx_empty;
        logic       busy;
        logic       nack;
        logic       tx_empty;
        logic       rx_full;
        logic [1:0] zero;
    } i2c_status_t;

    typedef struct packed {
        logic full;
        logic empty;
    } fifo_flags_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_addr,
        st_addr_ack,
        st_tx_byte,
        st_tx_ack,
        st_rx_byte,
        st_rx_ack,
        st_stop
    } i2c_state_e;

endpackage

`default_nettype wire

// File: common/i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// APB data word and I2C byte
`define I2C_DATA_W 8

`define I2C_PADDR_W 7

// depth is 2**I2C_FIFO_AW
`define I2C_FIFO_AW 3

// divider loaded at reset
`define I2C_PRESCALE_RST 8'd4

`endif
